//--- conv_engine.f
+incdir+dv
rtl/conv_types_pkg.sv
rtl/conv_ctrl_pkg.sv
rtl/conv_ctrl.sv
rtl/kernel_loader.sv
rtl/row_window.sv
rtl/window_mac.sv
rtl/conv_array.sv
rtl/conv_engine.sv
dv/conv_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --timescale 1ns/1ps \
	--top-module conv_engine_tb -f conv_engine.f -o sim_conv_engine

./obj_dir/sim_conv_engine | tee sim.log

if grep -qF '** FAIL **' sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -qF '** PASS **' sim.log; then
	echo "simulation ended without a verdict"
	exit 1
fi
echo "simulation passed"

//--- dv/conv_model.svh
weight_t m_w [9];
row_t    m_hist [3];	// 0 is the oldest row
int      m_rows;
int      m_pushed;
logic    m_beat;
state_e  m_state;
result_t exp_res_q [$];
int      exp_cyc_q [$];

function automatic void model_reset();
	m_state  = ST_WAIT;
	m_beat   = 1'b0;
	m_rows   = 0;
	m_pushed = 0;
endfunction

function automatic acc_t window_sum(input int pos);
	int sum;
	sum = 0;
	for (int r = 0; r < 3; r++) begin
		for (int c = 0; c < 3; c++) begin
			sum += int'(m_hist[r][8*(pos+c) +: 8]) * int'(m_w[3*r+c]);
		end
	end
	return acc_t'(sum);
endfunction

function automatic result_t expected_result(input logic stride_2);
	result_t res;
	res = '0;
	for (int k = 0; k < LANES; k++) begin
		if (!stride_2) begin
			res.lane[k] = window_sum(k);
		end else if (k < 3) begin
			res.lane[k] = window_sum(2 * k);	// positions 0, 2, 4
		end
	end
	return res;
endfunction

function automatic void model_step(input ctrl_cmd_e cmd, input logic wv,
	input logic [63:0] wd, input logic rv, input row_t r, input logic stride_2,
	input int cyc_now);
	if (m_state == ST_WAIT && wv) begin
		if (!m_beat) begin
			for (int n = 0; n < 8; n++) begin
				m_w[n] = wd[8*n +: 8];
			end
		end else begin
			m_w[8] = wd[7:0];
		end
		m_beat = !m_beat;
	end
	if (m_state == ST_COMPUTE && rv) begin
		m_hist[0] = m_hist[1];
		m_hist[1] = m_hist[2];
		m_hist[2] = r;
		m_rows++;
		if (m_rows == 3 || (m_rows > 3 && (!stride_2 || m_rows % 2 == 1))) begin
			exp_res_q.push_back(expected_result(stride_2));
			exp_cyc_q.push_back(cyc_now + 2);	// strobe one cycle after the row edge
			m_pushed++;
		end
	end
	case (m_state)
		ST_WAIT: begin
			if (cmd == CMD_START) begin
				m_state = ST_COMPUTE;
				m_rows  = 0;
			end else if (cmd == CMD_END) begin
				m_state = ST_FINISH;
			end
		end
		ST_COMPUTE: begin
			if (cmd == CMD_HOLD) begin
				m_state = ST_WAIT;
				m_beat  = 1'b0;
			end else if (cmd == CMD_END) begin
				m_state = ST_FINISH;
			end
		end
		default: begin
		end
	endcase
endfunction

//--- dv/conv_engine_tb.sv
`timescale 1ns/1ps

module conv_engine_tb
	import conv_types_pkg::*;
	import conv_ctrl_pkg::*;
();

	logic        clk;
	logic        rst;
	ctrl_cmd_e   ctrl;
	logic        w_valid;
	logic [63:0] w_data;
	logic        row_valid;
	row_t        row;
	logic        stride;
	logic        res_valid;
	result_t     res;
	logic        finish;

	logic [31:0] lcg_state = 32'hc22f2dca;
	int          cyc = 0;
	logic        mon_en;
	string       test_name;

	`include "conv_model.svh"

	conv_engine i_conv_engine (
		.clk         (clk),
		.rst         (rst),
		.i_ctrl      (ctrl),
		.i_w_valid   (w_valid),
		.i_w_data    (w_data),
		.i_row_valid (row_valid),
		.i_row       (row),
		.i_stride    (stride),
		.o_res_valid (res_valid),
		.o_res       (res),
		.o_finish    (finish)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual) begin
			stop_with_failure($sformatf("CHECK FAILED %s expected %0h actual %0h",
				name, expected, actual));
		end
	endtask

	// compare each result strobe with the oldest predicted one
	always @(negedge clk) begin
		if (mon_en && res_valid !== 1'b0) begin
			if (exp_res_q.size() == 0) begin
				stop_with_failure($sformatf("%s: result strobe with no result expected",
					test_name));
			end else begin
				check_value($sformatf("%s timing", test_name),
					128'(exp_cyc_q.pop_front()), 128'(cyc));
				check_value($sformatf("%s result", test_name),
					128'(exp_res_q.pop_front()), 128'(res));
			end
		end
	end

	task automatic drive(input ctrl_cmd_e cmd, input logic wv, input logic [63:0] wd,
		input logic rv, input row_t r);
		ctrl      = cmd;
		w_valid   = wv;
		w_data    = wd;
		row_valid = rv;
		row       = r;
		model_step(cmd, wv, wd, rv, r, stride, cyc);
		@(posedge clk);
		#1;
	endtask

	task automatic load_weights(input logic [63:0] beat_lo, input logic [63:0] beat_hi);
		drive(CMD_NOP, 1'b1, beat_lo, 1'b0, '0);
		drive(CMD_NOP, 1'b1, beat_hi, 1'b0, '0);
	endtask

	task automatic send_rows(input int n, input ctrl_cmd_e last_cmd, input logic saturate);
		row_t r;
		int   gap;
		for (int i = 0; i < n; i++) begin
			if (saturate) begin
				r   = '1;
				gap = 0;
			end else begin
				r   = {lcg_next(), lcg_next()};
				gap = int'(lcg_next() % 32'd3);
			end
			drive((i == n - 1) ? last_cmd : CMD_NOP, 1'b0, '0, 1'b1, r);
			for (int g = 0; g < gap && i < n - 1; g++) begin
				drive(CMD_NOP, 1'b1, {lcg_next(), lcg_next()}, 1'b0, '0);	// stray beats
			end
		end
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while (exp_res_q.size() != 0) begin
			if (n >= limit) begin
				stop_with_failure($sformatf("%s: timeout waiting for results", test_name));
			end else begin
				drive(CMD_NOP, 1'b0, '0, 1'b0, '0);
				n++;
			end
		end
	endtask

	task automatic expect_count(input int n);
		check_value($sformatf("%s predicted count", test_name), 128'(n), 128'(m_pushed));
		m_pushed = 0;
	endtask

	initial begin
		ctrl      = CMD_NOP;
		w_valid   = 1'b0;
		w_data    = '0;
		row_valid = 1'b0;
		row       = '0;
		stride    = 1'b0;
		rst       = 1'b0;
		mon_en    = 1'b0;
		test_name = "reset";
		model_reset();
		repeat (16) @(posedge clk);
		#1;
		rst    = 1'b1;
		mon_en = 1'b1;

		// rows in ST_WAIT are dropped
		for (int i = 0; i < 8; i++) begin
			drive(CMD_NOP, 1'b0, '0, 1'b1, {lcg_next(), lcg_next()});
			check_value("reset finish", 128'(0), 128'(finish));
		end

		test_name = "stride1";
		load_weights({lcg_next(), lcg_next()}, {lcg_next(), lcg_next()});
		drive(CMD_NOP, 1'b1, {lcg_next(), lcg_next()}, 1'b0, '0);	// odd beat count
		drive(CMD_START, 1'b0, '0, 1'b0, '0);
		send_rows(12, CMD_HOLD, 1'b0);	// last row shares its edge with HOLD
		wait_drained(20);
		expect_count(10);

		test_name = "saturated";
		load_weights('1, '1);
		drive(CMD_START, 1'b0, '0, 1'b0, '0);
		send_rows(4, CMD_NOP, 1'b1);
		drive(CMD_HOLD, 1'b0, '0, 1'b0, '0);
		wait_drained(20);
		expect_count(2);

		test_name = "stride2";
		load_weights({lcg_next(), lcg_next()}, {lcg_next(), lcg_next()});
		stride = 1'b1;
		drive(CMD_START, 1'b0, '0, 1'b0, '0);
		send_rows(11, CMD_HOLD, 1'b0);
		wait_drained(20);
		expect_count(5);
		stride = 1'b0;

		test_name = "finish";
		drive(CMD_START, 1'b0, '0, 1'b0, '0);
		send_rows(3, CMD_NOP, 1'b0);
		check_value("finish before END", 128'(0), 128'(finish));
		drive(CMD_END, 1'b0, '0, 1'b0, '0);
		check_value("finish after END", 128'(1), 128'(finish));
		wait_drained(20);
		for (int i = 0; i < 4; i++) begin
			drive(CMD_START, 1'b0, '0, 1'b1, {lcg_next(), lcg_next()});
			check_value("finish held", 128'(1), 128'(finish));
		end
		for (int i = 0; i < 4; i++) begin
			drive(CMD_NOP, 1'b0, '0, 1'b0, '0);
		end
		expect_count(1);

		$display("** PASS **");
		$finish;
	end

endmodule

//--- rtl/conv_engine.sv
`timescale 1ns/1ps

module conv_engine
	import conv_types_pkg::*;
	import conv_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  ctrl_cmd_e   i_ctrl,
	input  logic        i_w_valid,
	input  logic [63:0] i_w_data,
	input  logic        i_row_valid,
	input  row_t        i_row,
	input  logic        i_stride,	// 1 = stride 2
	output logic        o_res_valid,
	output result_t     o_res,
	output logic        o_finish
);

	logic    load_en;
	logic    run;
	logic    new_image;
	logic    hold;
	kernel_t kernel;
	window_t win;
	logic    win_strobe;

	conv_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.i_ctrl      (i_ctrl),
		.o_load_en   (load_en),
		.o_run       (run),
		.o_new_image (new_image),
		.o_hold      (hold),
		.o_finish    (o_finish)
	);

	kernel_loader u_kernel (
		.clk       (clk),
		.rst       (rst),
		.i_load_en (load_en),
		.i_hold    (hold),
		.i_w_valid (i_w_valid),
		.i_w_data  (i_w_data),
		.o_kernel  (kernel)
	);

	row_window u_window (
		.clk          (clk),
		.rst          (rst),
		.i_run        (run),
		.i_new_image  (new_image),
		.i_stride     (i_stride),
		.i_row_valid  (i_row_valid),
		.i_row        (i_row),
		.o_win        (win),
		.o_win_strobe (win_strobe)
	);

	conv_array u_array (
		.clk          (clk),
		.rst          (rst),
		.i_win        (win),
		.i_win_strobe (win_strobe),
		.i_kernel     (kernel),
		.i_stride     (i_stride),
		.o_res_valid  (o_res_valid),
		.o_res        (o_res)
	);

endmodule

//--- rtl/conv_array.sv
`timescale 1ns/1ps

module conv_array
	import conv_types_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  window_t i_win,
	input  logic    i_win_strobe,
	input  kernel_t i_kernel,
	input  logic    i_stride,
	output logic    o_res_valid,
	output result_t o_res
);

	acc_t    lane_sum [LANES];
	result_t res_nxt;

	for (genvar k = 0; k < LANES; k++) begin : g_lane
		window_t lane_win;

		// pixel k moves down to column 0
		assign lane_win.oldest = i_win.oldest >> (PIXEL_W * k);
		assign lane_win.middle = i_win.middle >> (PIXEL_W * k);
		assign lane_win.newest = i_win.newest >> (PIXEL_W * k);

		window_mac u_mac (
			.i_win    (lane_win),
			.i_kernel (i_kernel),
			.o_sum    (lane_sum[k])
		);
	end

	always_comb begin
		res_nxt = '0;
		if (i_stride) begin
			for (int k = 0; k < LANES / 2; k++) begin
				res_nxt.lane[k] = lane_sum[2*k];	// even positions, upper lanes zero
			end
		end else begin
			for (int k = 0; k < LANES; k++) begin
				res_nxt.lane[k] = lane_sum[k];
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_res_valid <= 1'b0;
		end else begin
			o_res_valid <= i_win_strobe;
		end
	end

	always_ff @(posedge clk) begin
		if (i_win_strobe) begin
			o_res <= res_nxt;
		end
	end

endmodule

//--- rtl/window_mac.sv
`timescale 1ns/1ps

module window_mac
	import conv_types_pkg::*;
(
	input  window_t i_win,	// already aligned to the lane
	input  kernel_t i_kernel,
	output acc_t    o_sum
);

	row_t    rows [KSIZE];
	pixel_t  pix;
	weight_t wgt;

	assign rows[0] = i_win.oldest;
	assign rows[1] = i_win.middle;
	assign rows[2] = i_win.newest;

	always_comb begin
		o_sum = '0;
		pix   = '0;
		wgt   = '0;
		for (int r = 0; r < KSIZE; r++) begin
			for (int c = 0; c < KSIZE; c++) begin
				pix   = rows[r][PIXEL_W*c +: PIXEL_W];
				wgt   = i_kernel[PIXEL_W*(KSIZE*r+c) +: PIXEL_W];
				o_sum = o_sum + acc_t'(pix) * acc_t'(wgt);
			end
		end
	end

endmodule

//--- rtl/row_window.sv
`timescale 1ns/1ps

module row_window
	import conv_types_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    i_run,
	input  logic    i_new_image,
	input  logic    i_stride,
	input  logic    i_row_valid,
	input  row_t    i_row,
	output window_t o_win,
	output logic    o_win_strobe
);

	logic [1:0] row_cnt;	// saturates at 3
	logic       phase;
	logic       row_acc;
	logic       win_done;

	assign row_acc = i_run && i_row_valid;

	// third row always completes, later rows depend on stride
	assign win_done = (row_cnt == 2'd2) ||
		((row_cnt == 2'd3) && (!i_stride || phase));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			row_cnt      <= 2'd0;
			phase        <= 1'b0;
			o_win_strobe <= 1'b0;
		end else begin
			o_win_strobe <= row_acc && win_done;
			if (i_new_image) begin
				row_cnt <= 2'd0;
				phase   <= 1'b0;
			end else if (row_acc) begin
				if (row_cnt != 2'd3) begin
					row_cnt <= row_cnt + 2'd1;
				end else begin
					phase <= ~phase;	// rows after the third
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (row_acc) begin
			o_win.oldest <= o_win.middle;
			o_win.middle <= o_win.newest;
			o_win.newest <= i_row;
		end
	end

endmodule

//--- rtl/kernel_loader.sv
`timescale 1ns/1ps

module kernel_loader
	import conv_types_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        i_load_en,
	input  logic        i_hold,
	input  logic        i_w_valid,
	input  logic [63:0] i_w_data,
	output kernel_t     o_kernel
);

	logic beat_sel;	// 0 -> weights 0..7, 1 -> weight 8
	logic beat_acc;

	assign beat_acc = i_load_en && i_w_valid;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			beat_sel <= 1'b0;
		end else if (i_hold) begin
			beat_sel <= 1'b0;
		end else if (beat_acc) begin
			beat_sel <= ~beat_sel;
		end
	end

	always_ff @(posedge clk) begin
		if (beat_acc) begin
			if (!beat_sel) begin
				o_kernel[8*PIXEL_W-1:0] <= i_w_data;
			end else begin
				o_kernel[9*PIXEL_W-1:8*PIXEL_W] <= i_w_data[PIXEL_W-1:0];	// upper bytes dropped
			end
		end
	end

endmodule

//--- rtl/conv_ctrl.sv
`timescale 1ns/1ps

module conv_ctrl
	import conv_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  ctrl_cmd_e i_ctrl,
	output logic      o_load_en,
	output logic      o_run,
	output logic      o_new_image,
	output logic      o_hold,
	output logic      o_finish
);

	state_e state;
	state_e state_nxt;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= ST_WAIT;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_WAIT: begin
				if (i_ctrl == CMD_START) begin
					state_nxt = ST_COMPUTE;
				end else if (i_ctrl == CMD_END) begin
					state_nxt = ST_FINISH;
				end
			end
			ST_COMPUTE: begin
				if (i_ctrl == CMD_HOLD) begin
					state_nxt = ST_WAIT;
				end else if (i_ctrl == CMD_END) begin
					state_nxt = ST_FINISH;
				end
			end
			default: begin
				state_nxt = ST_FINISH;	// only reset leaves
			end
		endcase
	end

	assign o_load_en   = (state == ST_WAIT);
	assign o_run       = (state == ST_COMPUTE);
	assign o_new_image = (state == ST_WAIT) && (i_ctrl == CMD_START);	// high on the START edge
	assign o_hold      = (state == ST_COMPUTE) && (i_ctrl == CMD_HOLD);
	assign o_finish    = (state == ST_FINISH);

endmodule

//--- rtl/conv_ctrl_pkg.sv
package conv_ctrl_pkg;

	typedef enum logic [1:0] {
		CMD_END   = 2'd0,
		CMD_START = 2'd1,
		CMD_HOLD  = 2'd2,
		CMD_NOP   = 2'd3
	} ctrl_cmd_e;

	typedef enum logic [1:0] {
		ST_WAIT,
		ST_COMPUTE,
		ST_FINISH
	} state_e;

endpackage

//--- rtl/conv_types_pkg.sv
package conv_types_pkg;

	parameter int PIXEL_W    = 8;
	parameter int ROW_PIXELS = 8;
	parameter int KSIZE      = 3;
	parameter int LANES      = ROW_PIXELS - KSIZE + 1;	// window positions per row
	parameter int ACC_W      = 20;	// nine 255*255 products fit

	typedef logic [PIXEL_W-1:0] pixel_t;
	typedef logic [PIXEL_W-1:0] weight_t;

	// pixel p at bit 8p
	typedef logic [ROW_PIXELS*PIXEL_W-1:0] row_t;

	// weight n = row*3 + col at bit 8n, row 0 oldest
	typedef logic [KSIZE*KSIZE*PIXEL_W-1:0] kernel_t;

	typedef logic [ACC_W-1:0] acc_t;

	typedef struct packed {
		row_t oldest;
		row_t middle;
		row_t newest;
	} window_t;

	typedef struct packed {
		acc_t [LANES-1:0] lane;	// lane 0 in lsbs
	} result_t;

endpackage
